//--- rtl/isaPkg.sv
package isaPkg;

	// Word and address geometry
	localparam int wordWidth = 18;
	localparam int addrWidth = 13;
	localparam int memDepth = 8192;		// 2**addrWidth words

	// Instruction fields, opcode on top
	localparam int opcodeMsb = 17;
	localparam int opcodeLsb = 15;
	localparam int modeMsb = 14;
	localparam int modeLsb = 13;
	localparam int addrMsb = 12;
	localparam int addrLsb = 0;

	typedef logic [wordWidth-1:0] word_t;	// Memory word, AC, MDR, IR
	typedef logic [addrWidth-1:0] addr_t;	// PC, MAR, address field

	// Codes 011 to 111 are not implemented
	typedef enum logic [2:0] {
		opAdd   = 3'b000,
		opLoad  = 3'b001,
		opStore = 3'b010
	} opcode_t;

	typedef enum logic [1:0] {
		modeDirect = 2'b01		// Address taken from the instruction
	} addrMode_t;

endpackage

//--- rtl/ctrlPkg.sv
package ctrlPkg;

	// One cycle per step
	typedef enum logic [3:0] {
		stFetchAddr,		// MAR <- PC
		stFetchRead,		// Memory read at MAR
		stFetchMdr,		// MDR <- read data
		stFetchIr,		// IR <- MDR, PC + 1
		stDecode,
		stExecAddr,		// MAR <- IR address field
		stExecRead,
		stExecWrite,		// Mem[MAR] <- AC
		stExecMdr,
		stExecAcc		// AC <- ALU result
	} ctrlState_t;

	// Same codes as the old ALU control field
	typedef enum logic [2:0] {
		aluPassB = 3'b001,	// Pass MDR
		aluAdd   = 3'b011	// AC + MDR
	} aluOp_t;

endpackage

//--- rtl/controlUnit.sv
`timescale 1ns/10ps

module controlUnit (
	input  logic               clk,
	input  logic               reset,
	input  isaPkg::opcode_t    irOpcode,
	input  isaPkg::addrMode_t  irMode,
	output logic               loadMar,
	output logic               marFromIr,
	output logic               incPc,
	output logic               loadIr,
	output logic               memRead,
	output logic               memWrite,
	output logic               loadMdr,
	output logic               loadAc,
	output ctrlPkg::aluOp_t    aluOp,
	output logic               instrDone
);

	ctrlPkg::ctrlState_t state;
	ctrlPkg::ctrlState_t nextState;
	logic isSupported;

	assign isSupported = (irMode == isaPkg::modeDirect) &&
		(irOpcode inside {isaPkg::opAdd, isaPkg::opLoad, isaPkg::opStore});

	always_comb
	begin
		case (state)
			ctrlPkg::stFetchAddr: nextState = ctrlPkg::stFetchRead;
			ctrlPkg::stFetchRead: nextState = ctrlPkg::stFetchMdr;
			ctrlPkg::stFetchMdr:  nextState = ctrlPkg::stFetchIr;
			ctrlPkg::stFetchIr:   nextState = ctrlPkg::stDecode;
			ctrlPkg::stDecode:
			begin
				if (isSupported)
					nextState = ctrlPkg::stExecAddr;
				else
					nextState = ctrlPkg::stFetchAddr;	// Unknown instruction is a no-op
			end
			ctrlPkg::stExecAddr:
			begin
				if (irOpcode == isaPkg::opStore)
					nextState = ctrlPkg::stExecWrite;
				else
					nextState = ctrlPkg::stExecRead;
			end
			ctrlPkg::stExecRead:  nextState = ctrlPkg::stExecMdr;
			ctrlPkg::stExecMdr:   nextState = ctrlPkg::stExecAcc;
			ctrlPkg::stExecAcc:   nextState = ctrlPkg::stFetchAddr;
			ctrlPkg::stExecWrite: nextState = ctrlPkg::stFetchAddr;
			default:              nextState = ctrlPkg::stFetchAddr;
		endcase
	end

	// Strobes are registered from the next state, so each one is high
	// for exactly the cycle spent in its state. The first fetch after
	// reset needs no MAR load since MAR and PC both start at zero.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= ctrlPkg::stFetchAddr;
			loadMar <= 1'b0;
			marFromIr <= 1'b0;
			incPc <= 1'b0;
			loadIr <= 1'b0;
			memRead <= 1'b0;
			memWrite <= 1'b0;
			loadMdr <= 1'b0;
			loadAc <= 1'b0;
			aluOp <= ctrlPkg::aluPassB;
		end
		else
		begin
			state <= nextState;
			loadMar <= 1'b0;
			marFromIr <= 1'b0;
			incPc <= 1'b0;
			loadIr <= 1'b0;
			memRead <= 1'b0;
			memWrite <= 1'b0;
			loadMdr <= 1'b0;
			loadAc <= 1'b0;
			aluOp <= ctrlPkg::aluPassB;
			case (nextState)
				ctrlPkg::stFetchAddr: loadMar <= 1'b1;		// MAR from PC
				ctrlPkg::stFetchRead: memRead <= 1'b1;
				ctrlPkg::stFetchMdr:  loadMdr <= 1'b1;
				ctrlPkg::stFetchIr:
				begin
					loadIr <= 1'b1;
					incPc <= 1'b1;
				end
				ctrlPkg::stExecAddr:
				begin
					loadMar <= 1'b1;
					marFromIr <= 1'b1;		// Direct address field
				end
				ctrlPkg::stExecRead:  memRead <= 1'b1;
				ctrlPkg::stExecMdr:   loadMdr <= 1'b1;
				ctrlPkg::stExecWrite: memWrite <= 1'b1;		// AC to memory
				ctrlPkg::stExecAcc:
				begin
					loadAc <= 1'b1;
					if (irOpcode == isaPkg::opAdd)
						aluOp <= ctrlPkg::aluAdd;
				end
				default: ;
			endcase
		end
	end

	// Last state of every instruction
	assign instrDone = (state == ctrlPkg::stExecAcc) ||
		(state == ctrlPkg::stExecWrite) ||
		((state == ctrlPkg::stDecode) && !isSupported);

endmodule

//--- rtl/addressPath.sv
`timescale 1ns/10ps

module addressPath (
	input  logic               clk,
	input  logic               reset,
	input  logic               loadMar,
	input  logic               marFromIr,
	input  logic               incPc,
	input  logic               loadIr,
	input  isaPkg::word_t      mdrValue,
	output isaPkg::addr_t      marValue,
	output isaPkg::addr_t      pcValue,
	output isaPkg::opcode_t    irOpcode,
	output isaPkg::addrMode_t  irMode
);

	isaPkg::addr_t pc;
	isaPkg::addr_t mar;
	isaPkg::word_t ir;
	isaPkg::addr_t irAddr;

	assign irAddr = ir[isaPkg::addrMsb:isaPkg::addrLsb];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= '0;
			mar <= '0;
			ir <= '0;
		end
		else
		begin
			if (incPc)
				pc <= pc + 1'b1;		// Wraps at memDepth
			if (loadIr)
				ir <= mdrValue;
			if (loadMar)
			begin
				if (marFromIr)
					mar <= irAddr;
				else
					mar <= pc;
			end
		end
	end

	// Fields straight off the IR
	assign irOpcode = isaPkg::opcode_t'(ir[isaPkg::opcodeMsb:isaPkg::opcodeLsb]);
	assign irMode = isaPkg::addrMode_t'(ir[isaPkg::modeMsb:isaPkg::modeLsb]);

	assign marValue = mar;
	assign pcValue = pc;

endmodule

//--- rtl/dataPath.sv
`timescale 1ns/10ps

module dataPath (
	input  logic             clk,
	input  logic             reset,
	input  logic             loadMdr,
	input  logic             loadAc,
	input  ctrlPkg::aluOp_t  aluOp,
	input  isaPkg::word_t    readData,
	output isaPkg::word_t    mdrValue,
	output isaPkg::word_t    acValue
);

	isaPkg::word_t mdr;
	isaPkg::word_t acc;
	isaPkg::word_t aluResult;

	// MDR only ever holds memory read data
	always_ff @(posedge clk)
	begin
		if (loadMdr)
			mdr <= readData;
	end

	// A side is always the accumulator, B side the MDR
	always_comb
	begin
		case (aluOp)
			ctrlPkg::aluAdd:   aluResult = acc + mdr;	// Carry out dropped
			ctrlPkg::aluPassB: aluResult = mdr;
			default:           aluResult = mdr;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			acc <= '0;
		else if (loadAc)
			acc <= aluResult;
	end

	assign mdrValue = mdr;
	assign acValue = acc;

endmodule

//--- rtl/dataMemory.sv
`timescale 1ns/10ps

module dataMemory (
	input  logic           clk,
	input  logic           memRead,
	input  logic           memWrite,
	input  isaPkg::addr_t  addr,
	input  isaPkg::word_t  writeData,
	input  logic           progWrite,
	input  isaPkg::addr_t  progAddr,
	input  isaPkg::word_t  progData,
	output isaPkg::word_t  readData
);

	isaPkg::word_t mem [isaPkg::memDepth];

	// Program port wins over the CPU write
	always_ff @(posedge clk)
	begin
		if (progWrite)
			mem[progAddr] <= progData;
		else if (memWrite)
			mem[addr] <= writeData;
	end

	// One cycle read, output holds between reads
	always_ff @(posedge clk)
	begin
		if (memRead)
			readData <= mem[addr];
	end

endmodule

//--- rtl/cpuTop.sv
`timescale 1ns/10ps

module cpuTop (
	input  logic           clk,
	input  logic           reset,
	input  logic           progWrite,
	input  isaPkg::addr_t  progAddr,
	input  isaPkg::word_t  progData,
	output isaPkg::word_t  acValue,
	output isaPkg::addr_t  pcValue,
	output logic           instrDone
);

	logic loadMar;
	logic marFromIr;
	logic incPc;
	logic loadIr;
	logic memRead;
	logic memWrite;
	logic loadMdr;
	logic loadAc;
	ctrlPkg::aluOp_t aluOp;
	isaPkg::opcode_t irOpcode;
	isaPkg::addrMode_t irMode;
	isaPkg::addr_t marValue;
	isaPkg::word_t mdrValue;
	isaPkg::word_t readData;

	controlUnit ctrl0 (
		.clk       (clk),
		.reset     (reset),
		.irOpcode  (irOpcode),
		.irMode    (irMode),
		.loadMar   (loadMar),
		.marFromIr (marFromIr),
		.incPc     (incPc),
		.loadIr    (loadIr),
		.memRead   (memRead),
		.memWrite  (memWrite),
		.loadMdr   (loadMdr),
		.loadAc    (loadAc),
		.aluOp     (aluOp),
		.instrDone (instrDone)
	);

	addressPath addr0 (
		.clk       (clk),
		.reset     (reset),
		.loadMar   (loadMar),
		.marFromIr (marFromIr),
		.incPc     (incPc),
		.loadIr    (loadIr),
		.mdrValue  (mdrValue),
		.marValue  (marValue),
		.pcValue   (pcValue),
		.irOpcode  (irOpcode),
		.irMode    (irMode)
	);

	dataPath data0 (
		.clk      (clk),
		.reset    (reset),
		.loadMdr  (loadMdr),
		.loadAc   (loadAc),
		.aluOp    (aluOp),
		.readData (readData),
		.mdrValue (mdrValue),
		.acValue  (acValue)
	);

	dataMemory mem0 (
		.clk       (clk),
		.memRead   (memRead),
		.memWrite  (memWrite),
		.addr      (marValue),
		.writeData (acValue),		// STORE source is the AC
		.progWrite (progWrite),
		.progAddr  (progAddr),
		.progData  (progData),
		.readData  (readData)
	);

endmodule

//--- tb/cpuTb.sv
`timescale 1ns/10ps

module cpuTb;

	localparam int clkPeriod = 20;
	localparam int resetCycles = 8;
	localparam int numTests = 5;
	localparam int totalInstr = 30;		// 2 + 4 + 4 + 20
	localparam int loadWords = 101;		// Program and data words over all tests
	localparam int pulseLimit = 18;		// Cycles allowed for one instruction
	localparam int resetTime = (numTests * (resetCycles + 2) + loadWords) * clkPeriod;
	localparam int watchdogTime = totalInstr * 9 * clkPeriod * 2 + resetTime;

	logic clk;
	logic reset;
	logic progWrite;
	isaPkg::addr_t progAddr;
	isaPkg::word_t progData;
	isaPkg::word_t acValue;
	isaPkg::addr_t pcValue;
	logic instrDone;

	int errors;
	int checks;
	integer seed;
	isaPkg::addr_t loadAddrQ[$];
	isaPkg::word_t loadDataQ[$];

	cpuTop dut0 (
		.clk       (clk),
		.reset     (reset),
		.progWrite (progWrite),
		.progAddr  (progAddr),
		.progData  (progData),
		.acValue   (acValue),
		.pcValue   (pcValue),
		.instrDone (instrDone)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// Opcode on top, then mode, then direct address
	function automatic isaPkg::word_t makeInstr(logic [2:0] op, logic [1:0] mode,
		isaPkg::addr_t addr);
		return {op, mode, addr};
	endfunction

	task automatic compareValues(logic [31:0] actual, logic [31:0] expected, string msg);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("FAILED at %0t: %s (got %h, expected %h)", $time, msg, actual, expected);
		end
	endtask

	task automatic addWord(isaPkg::addr_t addr, isaPkg::word_t data);
		loadAddrQ.push_back(addr);
		loadDataQ.push_back(data);
	endtask

	// Writes the queued words with reset held, then lets the CPU run
	task automatic runLoader();
		@(negedge clk);
		reset = 1'b1;
		foreach (loadAddrQ[i])
		begin
			@(negedge clk);
			progWrite = 1'b1;
			progAddr = loadAddrQ[i];
			progData = loadDataQ[i];
		end
		@(negedge clk);
		progWrite = 1'b0;
		repeat (resetCycles - 1) @(negedge clk);
		reset = 1'b0;
		loadAddrQ.delete();
		loadDataQ.delete();
	endtask

	// Returns one cycle after the pulse so the AC has settled
	task automatic waitInstr();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!instrDone && cycles < pulseLimit)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!instrDone)
		begin
			errors++;
			$display("No instruction finished within %0d cycles at %0t", pulseLimit, $time);
		end
		else
			@(negedge clk);
	endtask

	task automatic testResetState();
		@(negedge clk);
		reset = 1'b1;
		repeat (resetCycles)
		begin
			@(negedge clk);
			compareValues(acValue, 0, "AC during reset");
			compareValues(pcValue, 0, "PC during reset");
			compareValues(instrDone, 0, "instrDone during reset");
		end
		reset = 1'b0;
		repeat (2)
		begin
			@(negedge clk);
			compareValues(acValue, 0, "AC after reset");
			compareValues(pcValue, 0, "PC after reset");
			compareValues(instrDone, 0, "instrDone after reset");
		end
	endtask

	task automatic testLoadAdd();
		isaPkg::word_t a;
		isaPkg::word_t b;
		a = $random(seed);
		b = $random(seed);
		addWord(0, makeInstr(3'b001, 2'b01, 100));
		addWord(1, makeInstr(3'b000, 2'b01, 101));
		addWord(100, a);
		addWord(101, b);
		runLoader();
		waitInstr();
		compareValues(acValue, a, "AC after LOAD");
		waitInstr();
		compareValues(acValue, (a + b) & 18'h3ffff, "AC after ADD");
		compareValues(pcValue, 2, "PC after LOAD, ADD");
	endtask

	task automatic testStoreRoundTrip();
		isaPkg::word_t x;
		x = $random(seed);
		addWord(0, makeInstr(3'b001, 2'b01, 200));
		addWord(1, makeInstr(3'b010, 2'b01, 202));		// STORE x to y
		addWord(2, makeInstr(3'b001, 2'b01, 201));
		addWord(3, makeInstr(3'b001, 2'b01, 202));
		addWord(200, x);
		addWord(201, 0);
		runLoader();
		repeat (3) waitInstr();
		compareValues(acValue, 0, "AC after loading the zero word");
		waitInstr();
		compareValues(acValue, x, "AC after reading back the stored word");
		compareValues(pcValue, 4, "PC after STORE program");
	endtask

	task automatic testUnsupported();
		isaPkg::word_t v1;
		isaPkg::word_t v2;
		v1 = $random(seed);
		v2 = $random(seed);
		addWord(0, makeInstr(3'b001, 2'b01, 300));
		addWord(1, makeInstr(3'b011, 2'b01, 301));		// Unknown opcode
		addWord(2, makeInstr(3'b000, 2'b00, 301));		// ADD, not direct
		addWord(3, makeInstr(3'b001, 2'b01, 302));
		addWord(300, v1);
		addWord(301, 18'h15555);
		addWord(302, v2);
		runLoader();
		for (int i = 1; i <= 3; i++)
		begin
			waitInstr();
			compareValues(acValue, v1, "AC across no-op instructions");
			compareValues(pcValue, i, "PC counts no-op instructions");
		end
		waitInstr();
		compareValues(acValue, v2, "AC after final LOAD");
		compareValues(pcValue, 4, "PC after final LOAD");
	endtask

	task automatic testRandomSequence();
		isaPkg::word_t dataWords[64];
		logic isAdd[20];
		int offset[20];
		isaPkg::word_t expectedAc;
		for (int i = 0; i < 64; i++)
		begin
			dataWords[i] = $random(seed);
			addWord(1000 + i, dataWords[i]);
		end
		for (int i = 0; i < 20; i++)
		begin
			isAdd[i] = $random(seed) & 1;
			offset[i] = $random(seed) & 63;
			addWord(i, makeInstr(isAdd[i] ? 3'b000 : 3'b001, 2'b01, 1000 + offset[i]));
		end
		runLoader();
		expectedAc = 0;
		for (int i = 0; i < 20; i++)
		begin
			if (isAdd[i])
				expectedAc = (expectedAc + dataWords[offset[i]]) & 18'h3ffff;
			else
				expectedAc = dataWords[offset[i]];
			waitInstr();
			compareValues(acValue, expectedAc, $sformatf("AC after random instruction %0d", i));
			compareValues(pcValue, i + 1, $sformatf("PC after random instruction %0d", i));
		end
	endtask

	initial
	begin : watchdog
		#(watchdogTime);
		$display("Run timed out after %0d ns before all tests finished", watchdogTime);
		$display("Test failures found");
		$finish;
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		progWrite = 1'b0;
		progAddr = '0;
		progData = '0;
		errors = 0;
		checks = 0;
		seed = 32'hbf32;
		testResetState();
		testLoadAdd();
		testStoreRoundTrip();
		testUnsupported();
		testRandomSequence();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- filelist.f
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/controlUnit.sv
rtl/addressPath.sv
rtl/dataPath.sv
rtl/dataMemory.sv
rtl/cpuTop.sv
tb/cpuTb.sv
